/* compile.f */
+incdir+tb
source/fabric_pkg.sv
source/logic_cell.sv
source/clb_tile_unidir.sv
source/fabric_config_region.sv
source/fpga_unidir.sv
tb/fpga_unidir_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -f compile.f --top-module fpga_unidir_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vfpga_unidir_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation passed"
exit 0

/* source/clb_tile_unidir.sv */
`timescale 1ns/1ps

module clb_tile_unidir #(
  parameter int WS = 4
) (
  input  logic                  wb_clk_i,
  input  logic                  arst_n_i,
  input  logic                  cen_i,
  input  logic                  cfg_shift_i,
  input  fabric_pkg::cfg_word_t cfg_i,
  input  logic [WS-1:0]         west_i,
  output fabric_pkg::cfg_word_t cfg_o,
  output logic [WS-1:0]         east_o
);

  // Configuration chain through the cells
  // Entry 0 is the tile input, entry WS leaves the tile
  fabric_pkg::cfg_word_t cfg_chain [WS+1];

  // Registered cell outputs, shared by every cell as feedback
  logic [WS-1:0] q_bus;

  // Cell outputs toward the east
  logic [WS-1:0] cell_out;

  assign cfg_chain[0] = cfg_i;

  // Cell 0 takes the word first, cell WS-1 passes it on
  for (genvar i = 0; i < WS; i++) begin : g_cell
    logic_cell #(
      .WS(WS)
    ) logic_cell_i (
      .wb_clk_i   (wb_clk_i),
      .arst_n_i   (arst_n_i),
      .cen_i      (cen_i),
      .cfg_shift_i(cfg_shift_i),
      .cfg_i      (cfg_chain[i]),
      .west_i     (west_i),
      .fb_i       (q_bus),
      .cfg_o      (cfg_chain[i+1]),
      .q_o        (q_bus[i]),
      .out_o      (cell_out[i])
    );
  end

  // Chain end feeds the tile above
  assign cfg_o = cfg_chain[WS];

  // East wire i comes from cell i
  assign east_o = cell_out;

  // Shift pulse comes from a register block in another module
  // An unknown pulse would corrupt the whole column chain
  a_shift_known: assert property (
    @(posedge wb_clk_i) disable iff (!arst_n_i)
    !$isunknown(cfg_shift_i)
  ) else $error("clb_tile_unidir: configuration shift is unknown");

endmodule

/* source/fabric_config_region.sv */
`timescale 1ns/1ps

module fabric_config_region #(
  parameter int COLS_PER_REGION = 2,
  parameter int REGION_ID       = 0
) (
  input  logic                       wb_clk_i,
  input  logic                       arst_n_i,
  input  logic                       wbs_cyc_i,
  input  logic                       wbs_stb_i,
  input  logic                       wbs_we_i,
  input  fabric_pkg::wb_sel_t        wbs_sel_i,
  input  fabric_pkg::wb_addr_t       wbs_addr_i,
  input  fabric_pkg::wb_data_t       wbs_data_i,
  output logic                       wbs_ack_o,
  output fabric_pkg::wb_data_t       wbs_data_o,
  output fabric_pkg::cfg_word_t      cfg_o,
  output logic [COLS_PER_REGION-1:0] col_shift_o,
  output logic                       cen_o
);

  fabric_pkg::region_state_t  state_q;
  fabric_pkg::reg_offset_t    offset;
  fabric_pkg::push_count_t    push_count_q [COLS_PER_REGION];
  fabric_pkg::wb_data_t       rdata;
  fabric_pkg::wb_data_t       rdata_q;
  fabric_pkg::cfg_word_t      cfg_q;
  logic [COLS_PER_REGION-1:0] col_sel;
  logic [COLS_PER_REGION-1:0] shift_q;
  logic                       region_hit;
  logic                       accept;
  logic                       is_ctrl;
  logic                       full_word;
  logic                       cen_q;

  // Request aimed at this region
  assign region_hit = wbs_cyc_i && wbs_stb_i &&
                      (wbs_addr_i[fabric_pkg::REGION_FIELD_LSB +: fabric_pkg::REGION_FIELD_W] ==
                       fabric_pkg::region_id_t'(REGION_ID));

  // Taken only from idle, never in the ack cycle
  assign accept = region_hit && (state_q == fabric_pkg::REG_IDLE);

  // Offset decode
  assign offset    = wbs_addr_i[fabric_pkg::REGION_FIELD_LSB-1:0];
  assign is_ctrl   = (offset == fabric_pkg::CTRL_OFFSET);
  assign full_word = &wbs_sel_i;

  // One-hot column select, zero for unmapped offsets
  always_comb begin
    col_sel = '0;
    for (int c = 0; c < COLS_PER_REGION; c++) begin
      col_sel[c] = (offset == fabric_pkg::reg_offset_t'(fabric_pkg::COL_OFFSET_BASE + 4 * c));
    end
  end

  // Read mux
  always_comb begin
    rdata = '0;
    if (is_ctrl) begin
      rdata[0] = cen_q;
    end
    for (int c = 0; c < COLS_PER_REGION; c++) begin
      if (col_sel[c]) begin
        rdata = fabric_pkg::wb_data_t'(push_count_q[c]);
      end
    end
  end

  // Ack FSM, run enable, push counters and shift pulses
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= fabric_pkg::REG_IDLE;
      shift_q <= '0;
      cen_q   <= 1'b0;
      for (int c = 0; c < COLS_PER_REGION; c++) begin
        push_count_q[c] <= '0;
      end
    end else begin
      // Shift lasts only the ack cycle
      shift_q <= '0;
      case (state_q)
        fabric_pkg::REG_IDLE: begin
          if (accept) begin
            state_q <= fabric_pkg::REG_ACK;
            if (wbs_we_i && is_ctrl && wbs_sel_i[0]) begin
              cen_q <= wbs_data_i[0];
            end
            // Partial writes to a column are acked but dropped
            if (wbs_we_i && full_word) begin
              shift_q <= col_sel;
              for (int c = 0; c < COLS_PER_REGION; c++) begin
                if (col_sel[c] && (push_count_q[c] != '1)) begin
                  push_count_q[c] <= push_count_q[c] + 1'b1;
                end
              end
            end
          end
        end
        fabric_pkg::REG_ACK: begin
          state_q <= fabric_pkg::REG_IDLE;
        end
        default: begin
          state_q <= fabric_pkg::REG_IDLE;
        end
      endcase
    end
  end

  // Read data and the word for the column chains
  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      rdata_q <= wbs_we_i ? '0 : rdata;
      if (wbs_we_i && full_word) begin
        cfg_q <= wbs_data_i;
      end
    end
  end

  assign wbs_ack_o   = (state_q == fabric_pkg::REG_ACK);
  // Silent unless acking
  assign wbs_data_o  = wbs_ack_o ? rdata_q : '0;
  assign cfg_o       = cfg_q;
  assign col_shift_o = shift_q;
  assign cen_o       = cen_q;

  // Master sees a single ack per request
  a_ack_single: assert property (
    @(posedge wb_clk_i) disable iff (!arst_n_i)
    wbs_ack_o |=> !wbs_ack_o
  ) else $error("fabric_config_region: ack held for two cycles");

  // Only one column chain moves per push
  a_shift_onehot: assert property (
    @(posedge wb_clk_i) disable iff (!arst_n_i)
    $onehot0(col_shift_o)
  ) else $error("fabric_config_region: more than one column shifted");

endmodule

/* source/fabric_pkg.sv */
package fabric_pkg;

  // LUT geometry
  localparam int LUT_K   = 4;
  localparam int SEL_W   = 3;
  localparam int TRUTH_W = 2 ** LUT_K;

  // Configuration word layout
  // Truth table in the low half
  localparam int TRUTH_LSB = 0;
  // Four input selectors, input 0 lowest
  localparam int SEL_LSB   = 16;
  // Output flip-flop select
  localparam int REG_BIT   = 28;
  // Bits 31 to 29 carry nothing

  // Address map, region number above the register offset
  localparam int REGION_FIELD_LSB = 8;
  localparam int REGION_FIELD_W   = 4;

  // Wishbone bus fields
  typedef logic [31:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;
  typedef logic [3:0]  wb_sel_t;

  // Fabric configuration
  typedef logic [31:0]        cfg_word_t;
  typedef logic [TRUTH_W-1:0] truth_t;
  // Saturating count of pushes into one column
  typedef logic [15:0]        push_count_t;

  // Offset inside one region, and the region number itself
  typedef logic [REGION_FIELD_LSB-1:0] reg_offset_t;
  typedef logic [REGION_FIELD_W-1:0]   region_id_t;

  // Register offsets
  // Run enable in bit 0
  localparam reg_offset_t CTRL_OFFSET     = 8'h00;
  // Column c at base plus 4 times c
  localparam reg_offset_t COL_OFFSET_BASE = 8'h04;

  // Register block states
  typedef enum logic {
    REG_IDLE,
    REG_ACK
  } region_state_t;

endpackage

/* source/fpga_unidir.sv */
`timescale 1ns/1ps

module fpga_unidir #(
  parameter int MX                 = 4,
  parameter int MY                 = 2,
  parameter int WS                 = 4,
  parameter int NUM_CONFIG_REGIONS = 2
) (
  input  logic                  wb_clk_i,
  input  logic                  arst_n_i,
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_stb_i,
  input  logic                  wbs_we_i,
  input  fabric_pkg::wb_sel_t   wbs_sel_i,
  input  fabric_pkg::wb_addr_t  wbs_addr_i,
  input  fabric_pkg::wb_data_t  wbs_data_i,
  output logic                  wbs_ack_o,
  output fabric_pkg::wb_data_t  wbs_data_o,
  input  logic [MY*WS-1:0]      fabric_in_i,
  output logic [MY*WS-1:0]      fabric_out_o
);

  // Columns steered by each register block
  localparam int COLS_PER_REGION = MX / NUM_CONFIG_REGIONS;

  // Horizontal wires, entry x is the west side of column x
  logic [WS-1:0]         west_w [MY][MX+1];
  // Column chains, entry y enters row y
  fabric_pkg::cfg_word_t cfg_w [MY+1][MX];
  logic [MX-1:0]         col_shift;
  logic [MX-1:0]         col_cen;

  // Per-region returns and column controls
  fabric_pkg::cfg_word_t      region_cfg   [NUM_CONFIG_REGIONS];
  logic [COLS_PER_REGION-1:0] region_shift [NUM_CONFIG_REGIONS];
  fabric_pkg::wb_data_t       region_data  [NUM_CONFIG_REGIONS];
  logic [NUM_CONFIG_REGIONS-1:0] region_cen;
  logic [NUM_CONFIG_REGIONS-1:0] region_ack;

  // Tile grid, data flows west to east, config flows up
  for (genvar y = 0; y < MY; y++) begin : g_row
    assign west_w[y][0]              = fabric_in_i[y*WS +: WS];
    assign fabric_out_o[y*WS +: WS]  = west_w[y][MX];
    for (genvar x = 0; x < MX; x++) begin : g_col
      clb_tile_unidir #(
        .WS(WS)
      ) clb_tile_unidir_i (
        .wb_clk_i   (wb_clk_i),
        .arst_n_i   (arst_n_i),
        .cen_i      (col_cen[x]),
        .cfg_shift_i(col_shift[x]),
        .cfg_i      (cfg_w[y][x]),
        .west_i     (west_w[y][x]),
        .cfg_o      (cfg_w[y+1][x]),
        .east_o     (west_w[y][x+1])
      );
    end
  end

  // Register blocks, each beside its own columns
  for (genvar r = 0; r < NUM_CONFIG_REGIONS; r++) begin : g_region
    fabric_config_region #(
      .COLS_PER_REGION(COLS_PER_REGION),
      .REGION_ID      (r)
    ) fabric_config_region_i (
      .wb_clk_i   (wb_clk_i),
      .arst_n_i   (arst_n_i),
      .wbs_cyc_i  (wbs_cyc_i),
      .wbs_stb_i  (wbs_stb_i),
      .wbs_we_i   (wbs_we_i),
      .wbs_sel_i  (wbs_sel_i),
      .wbs_addr_i (wbs_addr_i),
      .wbs_data_i (wbs_data_i),
      .wbs_ack_o  (region_ack[r]),
      .wbs_data_o (region_data[r]),
      .cfg_o      (region_cfg[r]),
      .col_shift_o(region_shift[r]),
      .cen_o      (region_cen[r])
    );

    // Shared word into row 0, one shift per column, one enable for all
    for (genvar c = 0; c < COLS_PER_REGION; c++) begin : g_fan
      assign cfg_w[0][r*COLS_PER_REGION + c] = region_cfg[r];
      assign col_shift[r*COLS_PER_REGION + c] = region_shift[r][c];
      assign col_cen[r*COLS_PER_REGION + c]   = region_cen[r];
    end
  end

  // Idle regions return zero, so OR merges the bus
  always_comb begin
    wbs_data_o = '0;
    for (int r = 0; r < NUM_CONFIG_REGIONS; r++) begin
      wbs_data_o = wbs_data_o | region_data[r];
    end
  end

  assign wbs_ack_o = |region_ack;

endmodule

/* source/logic_cell.sv */
`timescale 1ns/1ps

module logic_cell #(
  parameter int WS = 4
) (
  input  logic                  wb_clk_i,
  input  logic                  arst_n_i,
  input  logic                  cen_i,
  input  logic                  cfg_shift_i,
  input  fabric_pkg::cfg_word_t cfg_i,
  input  logic [WS-1:0]         west_i,
  input  logic [WS-1:0]         fb_i,
  output fabric_pkg::cfg_word_t cfg_o,
  output logic                  q_o,
  output logic                  out_o
);

  fabric_pkg::cfg_word_t          cfg_q;
  fabric_pkg::truth_t             truth;
  logic [fabric_pkg::LUT_K-1:0]   lut_in;
  logic                           lut_out;
  logic                           ff_q;

  // Configuration stage, one position per shift pulse
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= '0;
    end else if (cfg_shift_i) begin
      cfg_q <= cfg_i;
    end
  end

  assign truth = cfg_q[fabric_pkg::TRUTH_LSB +: fabric_pkg::TRUTH_W];

  // Input selectors
  // Top selector bit picks feedback over west wires
  for (genvar k = 0; k < fabric_pkg::LUT_K; k++) begin : g_sel
    logic [fabric_pkg::SEL_W-1:0] sel;
    assign sel = cfg_q[fabric_pkg::SEL_LSB + k * fabric_pkg::SEL_W +: fabric_pkg::SEL_W];
    assign lut_in[k] = sel[fabric_pkg::SEL_W-1] ? fb_i[sel[fabric_pkg::SEL_W-2:0]]
                                                 : west_i[sel[fabric_pkg::SEL_W-2:0]];
  end

  // Truth table lookup
  assign lut_out = truth[lut_in];

  // Output flip-flop, held while the column is stopped
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ff_q <= 1'b0;
    end else if (cen_i) begin
      ff_q <= lut_out;
    end
  end

  // Registered or combinational output
  assign out_o = cfg_q[fabric_pkg::REG_BIT] ? ff_q : lut_out;

  // Flip-flop value always goes to feedback
  assign q_o   = ff_q;
  assign cfg_o = cfg_q;

endmodule

/* tb/fabric_model.svh */
`ifndef FABRIC_MODEL_SVH
`define FABRIC_MODEL_SVH

// Chain position p is row p / WS, cell p % WS of a column
fabric_pkg::cfg_word_t   cfg_mem   [MX][MY*WS];
logic                    ff_mem    [MX][MY*WS];
logic                    lut_mem   [MX][MY*WS];
logic                    cen_mem   [REGIONS];
fabric_pkg::push_count_t count_mem [MX];

function automatic int region_of(input fabric_pkg::wb_addr_t addr);
  return int'(addr[fabric_pkg::REGION_FIELD_LSB +: fabric_pkg::REGION_FIELD_W]);
endfunction

// Global column of a column register, -1 when not mapped
function automatic int column_of(input fabric_pkg::wb_addr_t addr);
  int off;
  off = int'(addr[fabric_pkg::REGION_FIELD_LSB-1:0]) - int'(fabric_pkg::COL_OFFSET_BASE);
  if (off < 0 || off % 4 != 0 || off / 4 >= COLS || region_of(addr) >= REGIONS) begin
    return -1;
  end
  return region_of(addr) * COLS + off / 4;
endfunction

task automatic reset_model();
  for (int x = 0; x < MX; x++) begin
    count_mem[x] = '0;
    for (int p = 0; p < MY * WS; p++) begin
      cfg_mem[x][p] = '0;
      ff_mem[x][p]  = 1'b0;
      lut_mem[x][p] = 1'b0;
    end
  end
  for (int r = 0; r < REGIONS; r++) begin
    cen_mem[r] = 1'b0;
  end
endtask

// Run enable, byte 0 only
task automatic update_enable(input fabric_pkg::wb_addr_t addr, input fabric_pkg::wb_data_t data,
                             input fabric_pkg::wb_sel_t sel);
  if (addr[fabric_pkg::REGION_FIELD_LSB-1:0] == fabric_pkg::CTRL_OFFSET && sel[0] &&
      region_of(addr) < REGIONS) begin
    cen_mem[region_of(addr)] = data[0];
  end
endtask

// Full-word push moves the column chain by one position
task automatic record_push(input fabric_pkg::wb_addr_t addr, input fabric_pkg::wb_data_t data,
                           input fabric_pkg::wb_sel_t sel);
  int col;
  col = column_of(addr);
  if (col >= 0 && sel == 4'hf) begin
    for (int p = MY * WS - 1; p > 0; p--) begin
      cfg_mem[col][p] = cfg_mem[col][p-1];
    end
    cfg_mem[col][0] = data;
    if (count_mem[col] != '1) begin
      count_mem[col] = count_mem[col] + 16'd1;
    end
  end
endtask

function automatic fabric_pkg::wb_data_t expected_read(input fabric_pkg::wb_addr_t addr);
  int col;
  col = column_of(addr);
  if (addr[fabric_pkg::REGION_FIELD_LSB-1:0] == fabric_pkg::CTRL_OFFSET &&
      region_of(addr) < REGIONS) begin
    return fabric_pkg::wb_data_t'(cen_mem[region_of(addr)]);
  end
  if (col >= 0) begin
    return fabric_pkg::wb_data_t'(count_mem[col]);
  end
  return '0;
endfunction

// Combinational pass west to east, LUT results kept for the next edge
task automatic evaluate(input fabric_bus_t fin, output fabric_bus_t fout);
  logic [WS-1:0]                west;
  logic [WS-1:0]                east;
  logic [fabric_pkg::SEL_W-1:0] sel;
  logic [fabric_pkg::LUT_K-1:0] idx;
  fabric_pkg::cfg_word_t        w;
  int                           p;
  for (int y = 0; y < MY; y++) begin
    west = fin[y*WS +: WS];
    for (int x = 0; x < MX; x++) begin
      for (int i = 0; i < WS; i++) begin
        p = y * WS + i;
        w = cfg_mem[x][p];
        for (int k = 0; k < fabric_pkg::LUT_K; k++) begin
          sel = w[fabric_pkg::SEL_LSB + k * fabric_pkg::SEL_W +: fabric_pkg::SEL_W];
          // 0 to 3 west wires, 4 to 7 flip-flops of the same tile
          idx[k] = (sel < 3'd4) ? west[sel[1:0]] : ff_mem[x][y * WS + int'(sel[1:0])];
        end
        lut_mem[x][p] = w[fabric_pkg::TRUTH_LSB + idx];
        east[i] = w[fabric_pkg::REG_BIT] ? ff_mem[x][p] : lut_mem[x][p];
      end
      west = east;
    end
    fout[y*WS +: WS] = west;
  end
endtask

// Only running regions load their flops
task automatic clock_flops();
  for (int x = 0; x < MX; x++) begin
    for (int p = 0; p < MY * WS; p++) begin
      if (cen_mem[x / COLS]) begin
        ff_mem[x][p] = lut_mem[x][p];
      end
    end
  end
endtask

`endif

/* tb/fpga_unidir_tb.sv */
`timescale 1ns/1ps

module fpga_unidir_tb;

  localparam int MX             = 4;
  localparam int MY             = 2;
  localparam int WS             = 4;
  localparam int REGIONS        = 2;
  localparam int COLS           = MX / REGIONS;
  localparam int TIMEOUT_CYCLES = 20000;

  typedef logic [MY*WS-1:0] fabric_bus_t;

  logic                 clk;
  logic                 arst_n;
  logic                 bus_cyc;
  logic                 bus_stb;
  logic                 bus_we;
  fabric_pkg::wb_sel_t  bus_sel;
  fabric_pkg::wb_addr_t bus_addr;
  fabric_pkg::wb_data_t bus_wdata;
  logic                 bus_ack;
  fabric_pkg::wb_data_t bus_rdata;
  fabric_bus_t          fabric_in;
  fabric_bus_t          fabric_out;
  logic [31:0]          seed;
  int                   cycles;

  `include "fabric_model.svh"

  fpga_unidir #(
    .MX                (MX),
    .MY                (MY),
    .WS                (WS),
    .NUM_CONFIG_REGIONS(REGIONS)
  ) fpga_unidir_i (
    .wb_clk_i    (clk),
    .arst_n_i    (arst_n),
    .wbs_cyc_i   (bus_cyc),
    .wbs_stb_i   (bus_stb),
    .wbs_we_i    (bus_we),
    .wbs_sel_i   (bus_sel),
    .wbs_addr_i  (bus_addr),
    .wbs_data_i  (bus_wdata),
    .wbs_ack_o   (bus_ack),
    .wbs_data_o  (bus_rdata),
    .fabric_in_i (fabric_in),
    .fabric_out_o(fabric_out)
  );

  always #5 clk = ~clk;

  // Run limit in clock cycles
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("Done: errors found");
      $fatal(1, "Timeout");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    seed = xorshift(seed);
    return seed;
  endfunction

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Done: errors found");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Model side of the coming rising edge
  // Output is checked before the flops move
  task automatic step_model();
    fabric_bus_t expected;
    evaluate(fabric_in, expected);
    compare(32'(fabric_out), 32'(expected), "fabric_out_o");
    clock_flops();
  endtask

  // Called on a falling edge and returns on the next one
  task automatic tick();
    step_model();
    @(negedge clk);
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      fabric_in = fabric_bus_t'(next_random());
      #1;
      tick();
    end
  endtask

  function automatic fabric_pkg::wb_addr_t ctrl_addr(input int r);
    return fabric_pkg::wb_addr_t'(r << fabric_pkg::REGION_FIELD_LSB) |
           fabric_pkg::wb_addr_t'(fabric_pkg::CTRL_OFFSET);
  endfunction

  function automatic fabric_pkg::wb_addr_t col_addr(input int x);
    return fabric_pkg::wb_addr_t'((x / COLS) << fabric_pkg::REGION_FIELD_LSB) |
           fabric_pkg::wb_addr_t'(fabric_pkg::COL_OFFSET_BASE + 4 * (x % COLS));
  endfunction

  // Single classic cycle with ack one cycle after the request
  task automatic transfer(input logic write, input fabric_pkg::wb_addr_t addr,
                          input fabric_pkg::wb_data_t data, input fabric_pkg::wb_sel_t sel);
    int waited;
    bus_cyc   = 1'b1;
    bus_stb   = 1'b1;
    bus_we    = write;
    bus_addr  = addr;
    bus_wdata = data;
    bus_sel   = sel;
    waited    = 0;
    tick();
    while (!bus_ack && waited < 4) begin
      tick();
      waited++;
    end
    if (!bus_ack) begin
      $display("No Wishbone ack within 4 cycles for address %h", addr);
      $display("Done: errors found");
      $fatal(1, "Bus timeout");
    end
    compare(32'(waited), 32'd0, "ack latency");
    if (!write) begin
      compare(bus_rdata, expected_read(addr), "read data");
    end
    bus_cyc = 1'b0;
    bus_stb = 1'b0;
    bus_we  = 1'b0;
    // Enable and push both land on the edge closing the ack cycle
    if (write) begin
      update_enable(addr, data, sel);
    end
    step_model();
    if (write) begin
      record_push(addr, data, sel);
    end
    @(negedge clk);
    compare(32'(bus_ack), 32'd0, "ack one cycle only");
  endtask

  task automatic read_all_registers();
    for (int r = 0; r < REGIONS; r++) begin
      transfer(1'b0, ctrl_addr(r), '0, 4'hf);
    end
    for (int x = 0; x < MX; x++) begin
      transfer(1'b0, col_addr(x), '0, 4'hf);
    end
  endtask

  // Fill every chain with REG_BIT kept or cleared
  task automatic load_columns(input logic reg_random);
    fabric_pkg::cfg_word_t w;
    for (int x = 0; x < MX; x++) begin
      for (int p = 0; p < MY * WS; p++) begin
        w = next_random();
        if (!reg_random) begin
          w[fabric_pkg::REG_BIT] = 1'b0;
        end
        transfer(1'b1, col_addr(x), w, 4'hf);
      end
    end
  endtask

  initial begin
    int r;
    int n;
    clk       = 1'b0;
    arst_n    = 1'b0;
    bus_cyc   = 1'b0;
    bus_stb   = 1'b0;
    bus_we    = 1'b0;
    bus_sel   = '0;
    bus_addr  = '0;
    bus_wdata = '0;
    fabric_in = '0;
    seed      = 32'h3e21;
    cycles    = 0;
    reset_model();
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Reset state
    compare(32'(bus_ack), 32'd0, "ack after reset");
    run_cycles(10);
    read_all_registers();

    // Control writes with byte 0 masked on the first one
    transfer(1'b1, ctrl_addr(0), 32'h1, 4'he);
    transfer(1'b0, ctrl_addr(0), '0, 4'hf);
    repeat (8) begin
      r = int'(next_random() % REGIONS);
      transfer(1'b1, ctrl_addr(r), next_random(), fabric_pkg::wb_sel_t'(next_random()));
      transfer(1'b0, ctrl_addr(r), '0, 4'hf);
    end
    transfer(1'b1, ctrl_addr(0), '0, 4'hf);
    transfer(1'b1, ctrl_addr(1), '0, 4'hf);

    // Push counts where a partial write is not counted
    for (int x = 0; x < MX; x++) begin
      n = int'(next_random() % 6) + 1;
      repeat (n) begin
        transfer(1'b1, col_addr(x), next_random(), 4'hf);
      end
      transfer(1'b1, col_addr(x), next_random(), 4'h7);
    end
    read_all_registers();

    // Combinational fabric with flops still at zero
    load_columns(1'b0);
    run_cycles(200);

    // Registered cells with region 1 stopped after a short run
    load_columns(1'b1);
    transfer(1'b1, ctrl_addr(0), 32'h1, 4'hf);
    transfer(1'b1, ctrl_addr(1), 32'h1, 4'hf);
    run_cycles(20);
    transfer(1'b1, ctrl_addr(1), '0, 4'hf);
    run_cycles(300);

    // Column 0 reloaded while region 1 runs
    transfer(1'b1, ctrl_addr(0), '0, 4'hf);
    transfer(1'b1, ctrl_addr(1), 32'h1, 4'hf);
    for (int p = 0; p < MY * WS; p++) begin
      transfer(1'b1, col_addr(0), next_random(), 4'hf);
    end
    run_cycles(100);
    transfer(1'b1, ctrl_addr(0), 32'h1, 4'hf);
    run_cycles(100);
    read_all_registers();

    $display("Done: no errors");
    $finish;
  end

endmodule
